// File: Makefile
# Verilator build and run of the sample bridge testbench

VERILATOR ?= verilator
TOP       ?= tbSampleBridge
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not from the simulator status
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/asyncFifo.sv
//==========================================================================
// Dual-clock FIFO with Gray pointers and a direction flag
// Full and empty assert asynchronously and release through two flops
//==========================================================================
`timescale 1ns/1ps
`include "bridge_macros.svh"

module asyncFifo
    import streamPkg::*, fifoPkg::*;
(
    input  logic       rclk,      // Read clock
    input  logic       wclk,      // Write clock
    input  logic       arok,      // Async reset, active low
    input  logic       rtrigger,  // Pop strobe
    output taggedWordT rdata,     // Word at the read pointer
    output logic       rok,       // Data available
    input  logic       wtrigger,  // Push strobe
    input  taggedWordT wdata,     // Word to push
    output logic       wok        // Space available
);

    localparam int N = $bits(fifoPtrT) - 1;  // Top pointer bit

    taggedWordT mem [`FIFO_DEPTH];  // Storage, no reset

    fifoPtrT rbAddr, rgAddr;          // Read pointer, binary and Gray
    fifoPtrT wbAddr, wgAddr;          // Write pointer, binary and Gray
    fifoPtrT wgAddrDelayed;           // Gray write pointer one wclk later
    fifoPtrT rbAddrNext, wbAddrNext;  // Incremented binary pointers

    logic [1:0] rokSr;  // Empty release shift register
    logic [1:0] wokSr;  // Full release shift register
    logic       dir;    // 1 when writer is catching up on reader
    logic       emptyN, fullN;
    logic       dirSet, dirClr, dirClrAll;

    //======================================================================
    // Read side
    //======================================================================
    assign rbAddrNext = rbAddr + 1'b1;

    always_ff @(posedge rclk, negedge arok) begin
        if (!arok) begin
            rbAddr <= '0;
            rgAddr <= '0;
        end else if (rtrigger && rok) begin
            rbAddr <= rbAddrNext;
            rgAddr <= (rbAddrNext >> 1) ^ rbAddrNext;  // Binary to Gray
        end
    end

    // Drops at once on empty, rises two rclk edges later
    always_ff @(posedge rclk, negedge emptyN) begin
        if (!emptyN) begin
            rokSr <= 2'b00;
        end else begin
            rokSr <= {rokSr[0], 1'b1};
        end
    end

    assign rdata = mem[rbAddr];  // Asynchronous read
    assign rok   = rokSr[1];

    //======================================================================
    // Write side
    //======================================================================
    assign wbAddrNext = wbAddr + 1'b1;

    always_ff @(posedge wclk) begin
        if (wtrigger && wok) begin
            mem[wbAddr] <= wdata;
        end
    end

    always_ff @(posedge wclk, negedge arok) begin
        if (!arok) begin
            wbAddr        <= '0;
            wgAddr        <= '0;
            wgAddrDelayed <= '0;
        end else begin
            wgAddrDelayed <= wgAddr;  // Word settles in memory first
            if (wtrigger && wok) begin
                wbAddr <= wbAddrNext;
                wgAddr <= (wbAddrNext >> 1) ^ wbAddrNext;
            end
        end
    end

    // Drops on the filling write, recovers two wclk edges after a pop
    always_ff @(posedge wclk, negedge fullN) begin
        if (!fullN) begin
            wokSr <= 2'b00;
        end else begin
            wokSr <= {wokSr[0], 1'b1};
        end
    end

    assign wok = wokSr[1];

    //======================================================================
    // Asynchronous flags
    //======================================================================
    assign emptyN = (rgAddr != wgAddrDelayed) || dir;  // Not empty
    assign fullN  = (rgAddr != wgAddr) || !dir;        // Not full

    // Quadrant compare of the Gray pointers
    assign dirClr = (rgAddr[N] != wgAddr[N-1]) & (rgAddr[N-1] == wgAddr[N]);
    assign dirSet = (rgAddr[N] == wgAddr[N-1]) & (rgAddr[N-1] != wgAddr[N]);
    assign dirClrAll = dirClr | !arok;  // Reset also clears direction

    always_ff @(posedge dirClrAll, posedge dirSet) begin
        if (dirClrAll) begin
            dir <= 1'b0;  // Reader is going toward empty
        end else begin
            dir <= 1'b1;  // Writer is going toward full
        end
    end

endmodule

// File: rtl/bridge_macros.svh
//==========================================================================
// Fixed widths and depth of the sample bridge
// Included by the packages and by the FIFO for its memory size
//==========================================================================
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// Raw sample width from the producer
`define SAMPLE_W 12

// Sequence tag width, tags wrap modulo 16
`define SEQ_W 4

// FIFO entries
// Must be a power of two and at least 4
`define FIFO_DEPTH 8

// Saturating drop counter width
`define DROP_W 8

`endif

// File: rtl/fifoPkg.sv
//==========================================================================
// FIFO bookkeeping types, pointers and per-domain reset release
//==========================================================================
`include "bridge_macros.svh"

package fifoPkg;

    // Binary or Gray FIFO address, no extra wrap bit
    // Full and empty are told apart by the direction flag
    typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifoPtrT;

    // Two-flop reset release as a small FSM
    typedef enum logic [1:0] {
        inReset,    // arok low, stage holds
        releasing,  // First clock after release
        running     // Stage takes inputs
    } rstSyncT;

endpackage

// File: rtl/gapDetector.sv
//==========================================================================
// Read stage, pops on enable and reports gaps in the sequence tags
// Output strobe comes one rclk after the pop
//==========================================================================
`timescale 1ns/1ps

module gapDetector
    import streamPkg::*, fifoPkg::*;
(
    input  logic       rclk,       // Read clock
    input  logic       arok,       // Async reset, active low
    input  logic       popEnable,  // Consumer level
    input  logic       rok,        // FIFO has data
    input  taggedWordT rdata,      // Word at the FIFO head
    output logic       rtrigger,   // Pop strobe to the FIFO
    output logic       outStrobe,  // One pulse per delivered sample
    output sampleT     outSample,  // Delivered sample
    output logic       gapFlag,    // Samples were lost before this one
    output seqT        gapLen      // Number of lost samples
);

    rstSyncT rRst;      // Reset release state in rclk domain
    logic    rRunning;  // Stage may pop
    logic    pop;       // Word taken this cycle
    seqT     expTag;    // Tag expected next

    //======================================================================
    // Reset release
    //======================================================================
    always_ff @(posedge rclk, negedge arok) begin
        if (!arok) begin
            rRst <= inReset;
        end else begin
            case (rRst)
                inReset: rRst <= releasing;
                default: rRst <= running;
            endcase
        end
    end

    assign rRunning = (rRst == running);

    //======================================================================
    // Pop
    //======================================================================
    assign rtrigger = rRunning & popEnable & rok;
    assign pop      = rtrigger;  // FIFO pops on the same condition

    //======================================================================
    // Control and tag tracking
    //======================================================================
    always_ff @(posedge rclk, negedge arok) begin
        if (!arok) begin
            outStrobe <= 1'b0;
            gapFlag   <= 1'b0;
            expTag    <= '0;   // First sample carries tag 0
        end else begin
            outStrobe <= pop;
            gapFlag   <= pop && (rdata.seq != expTag);  // Only with the strobe
            if (pop) begin
                expTag <= rdata.seq + 1'b1;  // Resync on the received tag
            end
        end
    end

    // Payload, valid while outStrobe is high
    always_ff @(posedge rclk) begin
        if (pop) begin
            outSample <= rdata.sample;
            gapLen    <= rdata.seq - expTag;  // Modulo 16 distance
        end
    end

endmodule

// File: rtl/sampleBridge.sv
//==========================================================================
// Top of the sample bridge, tagger then FIFO then gap detector
//==========================================================================
`timescale 1ns/1ps

module sampleBridge
    import streamPkg::*;
(
    input  logic      rclk,          // Read clock
    input  logic      wclk,          // Write clock
    input  logic      arok,          // Async reset, active low
    input  logic      sampleStrobe,  // Producer pulse
    input  sampleT    sample,        // Producer value
    input  logic      popEnable,     // Consumer level
    output logic      outStrobe,     // Delivery pulse
    output sampleT    outSample,     // Delivered value
    output logic      gapFlag,       // Loss before this delivery
    output seqT       gapLen,        // Size of that loss
    output dropCountT dropCount      // Total drops at the writer
);

    logic       wtrigger, wok;  // Write side handshake levels
    taggedWordT wdata;
    logic       rtrigger, rok;  // Read side
    taggedWordT rdata;

    sampleTagger tagger_i (
        .wclk         (wclk),
        .arok         (arok),
        .sampleStrobe (sampleStrobe),
        .sample       (sample),
        .wok          (wok),
        .wtrigger     (wtrigger),
        .wdata        (wdata),
        .dropCount    (dropCount)
    );

    asyncFifo fifo_i (
        .rclk     (rclk),
        .wclk     (wclk),
        .arok     (arok),
        .rtrigger (rtrigger),
        .rdata    (rdata),
        .rok      (rok),
        .wtrigger (wtrigger),
        .wdata    (wdata),
        .wok      (wok)
    );

    gapDetector detector_i (
        .rclk      (rclk),
        .arok      (arok),
        .popEnable (popEnable),
        .rok       (rok),
        .rdata     (rdata),
        .rtrigger  (rtrigger),
        .outStrobe (outStrobe),
        .outSample (outSample),
        .gapFlag   (gapFlag),
        .gapLen    (gapLen)
    );

endmodule

// File: rtl/sampleTagger.sv
//==========================================================================
// Write stage, tags each sample and pushes it while the FIFO has space
// Samples arriving on a full FIFO are dropped and counted
//==========================================================================
`timescale 1ns/1ps

module sampleTagger
    import streamPkg::*, fifoPkg::*;
(
    input  logic       wclk,          // Write clock
    input  logic       arok,          // Async reset, active low
    input  logic       sampleStrobe,  // One pulse per sample
    input  sampleT     sample,        // Sample value
    input  logic       wok,           // FIFO has space
    output logic       wtrigger,      // Push strobe to the FIFO
    output taggedWordT wdata,         // Tagged word to the FIFO
    output dropCountT  dropCount      // Saturating drop count
);

    rstSyncT wRst;      // Reset release state in wclk domain
    logic    wRunning;  // Stage may take samples
    seqT     seqCnt;    // Tag for the next sample

    //======================================================================
    // Reset release
    //======================================================================
    always_ff @(posedge wclk, negedge arok) begin
        if (!arok) begin
            wRst <= inReset;
        end else begin
            case (wRst)
                inReset: wRst <= releasing;  // First flop
                default: wRst <= running;    // Second flop, then stays
            endcase
        end
    end

    assign wRunning = (wRst == running);

    //======================================================================
    // Tagging and push
    //======================================================================
    assign wdata.seq    = seqCnt;  // Current tag
    assign wdata.sample = sample;  // Passed straight through

    // Push in the same cycle as the strobe
    assign wtrigger = wRunning & sampleStrobe & wok;

    // Tag advances on every strobe
    // So a dropped sample leaves a hole in the sequence
    always_ff @(posedge wclk, negedge arok) begin
        if (!arok) begin
            seqCnt <= '0;
        end else if (wRunning && sampleStrobe) begin
            seqCnt <= seqCnt + 1'b1;
        end
    end

    //======================================================================
    // Drop counter
    //======================================================================
    always_ff @(posedge wclk, negedge arok) begin
        if (!arok) begin
            dropCount <= '0;
        end else if (wRunning && sampleStrobe && !wok) begin
            if (dropCount != '1) begin      // Hold at max
                dropCount <= dropCount + 1'b1;
            end
        end
    end

endmodule

// File: rtl/streamPkg.sv
//==========================================================================
// Types of the sample stream as it crosses the bridge
//==========================================================================
`include "bridge_macros.svh"

package streamPkg;

    // One sample value as delivered by the producer
    typedef logic [`SAMPLE_W-1:0] sampleT;

    // Sequence tag, modulo 2**SEQ_W
    typedef logic [`SEQ_W-1:0] seqT;

    // Count of samples lost on a full FIFO, saturates at all ones
    typedef logic [`DROP_W-1:0] dropCountT;

    // FIFO word, tag in the upper bits
    typedef struct packed {
        seqT    seq;     // Tag given by the write stage
        sampleT sample;  // Payload
    } taggedWordT;

endpackage

// File: sim/bridgeChecker.sv
//==========================================================================
// Testbench checker, models the tagged stream and compares bridge outputs
// Watches the DUT ports only and hands its counts to the testbench top
//==========================================================================
`timescale 1ns/1ps
`include "bridge_macros.svh"

module bridgeChecker
    import streamPkg::*;
(
    input  logic      rclk,            // Read clock
    input  logic      wclk,            // Write clock
    input  logic      arok,            // Async reset, active low
    input  logic      sampleStrobe,    // Producer pulse
    input  sampleT    sample,          // Producer value
    input  logic      outStrobe,       // Delivery pulse
    input  sampleT    outSample,       // Delivered value
    input  logic      gapFlag,         // Loss reported by the DUT
    input  seqT       gapLen,          // Size of that loss
    input  dropCountT dropCount,       // DUT drop counter
    output int        sentCount,       // Strobes seen
    output int        deliveredCount,  // outStrobe pulses seen
    output int        gapSum,          // Sum of reported gapLen
    output int        errorCount       // Mismatches found
);

    localparam int LOG_SIZE = 256;  // Ring of kept samples

    taggedWordT keptLog [LOG_SIZE];  // Samples the FIFO should hold
    int         keptIdx        = 0;  // Next free log slot
    int         readIdx        = 0;  // Oldest undelivered slot
    int         sent           = 0;
    int         modelDrops     = 0;  // Drops the model predicts
    int         delivered      = 0;
    int         sumGap         = 0;
    int         deliveryErrors = 0;
    int         dropErrors     = 0;
    int         lastModelDrops = 0;
    dropCountT  lastDropCount  = '0;
    seqT        nextTag        = '0;  // Tag the writer gives next
    seqT        expTag         = '0;  // Tag the reader expects next

    assign sentCount      = sent;
    assign deliveredCount = delivered;
    assign gapSum         = sumGap;
    assign errorCount     = deliveryErrors + dropErrors;

    function automatic int reportMismatch(input string name, input int expVal,
                                          input int actVal);
        if (expVal == actVal) begin
            return 0;
        end
        $display("[ERROR] %0t ns %s expected 0x%0h, actual 0x%0h",
                 $time, name, expVal, actVal);
        return 1;
    endfunction

    //======================================================================
    // Write side model
    //======================================================================
    always @(posedge wclk) begin : recordSent
        taggedWordT word;
        if (arok && sampleStrobe) begin
            word.seq    = nextTag;
            word.sample = sample;
            if (keptIdx - readIdx < `FIFO_DEPTH) begin  // Space left
                keptLog[keptIdx % LOG_SIZE] = word;
                keptIdx++;
            end else begin
                modelDrops++;                        // FIFO full, lost
            end
            nextTag = nextTag + 1'b1;                // Advances on every strobe
            sent++;
        end
    end

    // Compare whenever either count moves
    always @(negedge wclk) begin
        if (arok && (dropCount != lastDropCount || modelDrops != lastModelDrops)) begin
            dropErrors += reportMismatch("dropCount", modelDrops, dropCount);
            lastDropCount  = dropCount;
            lastModelDrops = modelDrops;
        end
    end

    //======================================================================
    // Read side compare
    //======================================================================
    always @(negedge rclk) begin : checkDelivery
        taggedWordT head;
        seqT        gapExp;
        if (arok && outStrobe) begin
            if (readIdx == keptIdx) begin
                deliveryErrors++;
                $display("%0t ns: outStrobe pulsed with no sample pending", $time);
            end else begin
                head   = keptLog[readIdx % LOG_SIZE];
                gapExp = head.seq - expTag;          // Lost tags, modulo 16
                readIdx++;
                deliveryErrors += reportMismatch("outSample", head.sample, outSample);
                deliveryErrors += reportMismatch("gapFlag", gapExp != 0, gapFlag);
                deliveryErrors += reportMismatch("gapLen", gapExp, gapLen);
                expTag = head.seq + 1'b1;
            end
            sumGap += gapLen;
            delivered++;
        end
    end

endmodule

// File: sim/tbSampleBridge.sv
//==========================================================================
// Testbench top, clocks, reset and a stimulus table applied row by row
//==========================================================================
`timescale 1ns/1ps

module tbSampleBridge
    import streamPkg::*;
();

    localparam int TIMEOUT  = 1000;  // Cycles allowed per wait
    localparam int NUM_ROWS = 8;

    typedef struct packed {
        logic       popOn;     // popEnable during the row
        logic [7:0] burst;     // Strobes to send
        logic [7:0] spacing;   // Idle wclk cycles between strobes
        logic [7:0] expDeliv;  // Deliveries expected
        logic [7:0] expDrops;  // Drops expected
    } stimRowT;

    logic        rclk = 1'b0;
    logic        wclk = 1'b0;
    logic        arok, sampleStrobe, popEnable;
    sampleT      sample;
    logic        outStrobe, gapFlag;
    sampleT      outSample;
    seqT         gapLen;
    dropCountT   dropCount;
    int          sentCount, deliveredCount, gapSum, errorCount;  // From checker
    stimRowT     stimTable [NUM_ROWS];
    logic [15:0] lfsr      = 16'd49;  // Seed
    int          failCount = 0;
    bit          timedOut  = 1'b0;

    always #2 rclk = ~rclk;  // 4 ns
    always #3 wclk = ~wclk;  // 6 ns, unrelated to rclk

    sampleBridge  dut_i     (.*);
    bridgeChecker checker_i (.*);

    // Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic nextSample(output sampleT value);
        value = '0;
        for (int i = 0; i < $bits(sampleT); i++) begin
            value = {value[$bits(sampleT)-2:0], lfsr[0]};  // One step per bit
            lfsr  = lfsrStep(lfsr);
        end
    endtask

    task automatic sendBurst(input int count, input int spacing);
        sampleT value;
        @(negedge wclk);
        for (int n = 0; n < count; n++) begin
            nextSample(value);
            sample       = value;
            sampleStrobe = 1'b1;
            @(negedge wclk);
            sampleStrobe = 1'b0;
            repeat (spacing) @(negedge wclk);
        end
    endtask

    task automatic waitDelivered(input int target);
        int cycles;
        cycles = 0;
        while (deliveredCount < target && cycles < TIMEOUT) begin
            @(posedge rclk);  // Checker counts on the falling edge
            cycles++;
        end
        if (deliveredCount < target) begin
            timedOut = 1'b1;
            $display("Timeout waiting for %0d deliveries, saw %0d", target, deliveredCount);
        end
    endtask

    task automatic waitDropped(input int target);
        int cycles;
        cycles = 0;
        while (dropCount < target && cycles < TIMEOUT) begin
            @(negedge wclk);
            cycles++;
        end
        if (dropCount < target) begin
            timedOut = 1'b1;
            $display("Timeout waiting for dropCount %0d, saw %0d", target, dropCount);
        end
    endtask

    // Nothing may come out and nothing may drop before the first strobe
    task automatic checkIdle();
        bit quiet;
        quiet = 1'b1;
        for (int c = 0; c < TIMEOUT; c++) begin
            @(negedge rclk);
            if (outStrobe !== 1'b0 || dropCount !== '0) quiet = 1'b0;
        end
        if (!quiet) failCount++;
        $display("Idle after reset: %s", quiet ? "ok" : "output moved without input");
    endtask

    task automatic runRow(input int r);
        stimRowT row;
        int      startDeliv, startDrops, gotDeliv, gotDrops;
        bit      rowOk;
        row        = stimTable[r];
        startDeliv = deliveredCount;
        startDrops = dropCount;
        @(negedge rclk);
        popEnable = row.popOn;
        sendBurst(row.burst, row.spacing);
        if (row.popOn) waitDelivered(startDeliv + row.expDeliv);
        else           waitDropped(startDrops + row.expDrops);
        gotDeliv = deliveredCount - startDeliv;
        gotDrops = dropCount - startDrops;
        rowOk    = !timedOut;
        if (gotDeliv != row.expDeliv) begin
            rowOk = 1'b0;
            $display("[ERROR] %0t ns outStrobe count expected %0d, actual %0d",
                     $time, row.expDeliv, gotDeliv);
        end
        if (gotDrops != row.expDrops) begin
            rowOk = 1'b0;
            $display("[ERROR] %0t ns dropCount rise expected %0d, actual %0d",
                     $time, row.expDrops, gotDrops);
        end
        if (!rowOk) failCount++;
        $display("Row %0d popEnable=%0d burst=%0d delivered %0d/%0d dropped %0d/%0d",
                 r, row.popOn, row.burst, gotDeliv, row.expDeliv, gotDrops, row.expDrops);
    endtask

    //======================================================================
    // Main sequence
    //======================================================================
    initial begin
        arok         = 1'b0;
        sampleStrobe = 1'b0;
        sample       = '0;
        popEnable    = 1'b0;
        //               pop   burst  space  deliv  drops
        stimTable[0] = '{1'b1, 8'd10, 8'd3, 8'd10, 8'd0};  // Clean stream
        stimTable[1] = '{1'b0, 8'd12, 8'd1, 8'd0,  8'd4};  // Fill, drop 4
        stimTable[2] = '{1'b1, 8'd0,  8'd0, 8'd8,  8'd0};  // Drain the 8 kept
        stimTable[3] = '{1'b1, 8'd4,  8'd3, 8'd4,  8'd0};  // First has gapLen 4
        stimTable[4] = '{1'b1, 8'd20, 8'd4, 8'd20, 8'd0};  // Tags wrap
        stimTable[5] = '{1'b0, 8'd9,  8'd2, 8'd0,  8'd1};  // Drop 1
        stimTable[6] = '{1'b1, 8'd0,  8'd0, 8'd8,  8'd0};
        stimTable[7] = '{1'b1, 8'd3,  8'd5, 8'd3,  8'd0};  // gapLen 1
        repeat (3) @(posedge rclk);
        @(negedge rclk);
        arok = 1'b1;
        checkIdle();
        for (int r = 0; r < NUM_ROWS && !timedOut; r++) runRow(r);
        if (sentCount != deliveredCount + dropCount) begin
            failCount++;
            $display("[ERROR] %0t ns deliveries plus dropCount expected %0d, actual %0d",
                     $time, sentCount, deliveredCount + dropCount);
        end
        if (gapSum != dropCount) begin
            failCount++;
            $display("[ERROR] %0t ns gapLen sum expected %0d, actual %0d",
                     $time, dropCount, gapSum);
        end
        $display("Rows %0d, failed %0d, errors %0d, sent %0d, delivered %0d, dropped %0d",
                 NUM_ROWS, failCount, errorCount, sentCount, deliveredCount, dropCount);
        if (failCount == 0 && errorCount == 0 && !timedOut) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+rtl
rtl/streamPkg.sv
rtl/fifoPkg.sv
rtl/sampleTagger.sv
rtl/asyncFifo.sv
rtl/gapDetector.sv
rtl/sampleBridge.sv
sim/bridgeChecker.sv
sim/tbSampleBridge.sv
